//--- logic/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

//////////////////////////////
// cache geometry
//////////////////////////////

// byte address and cpu word
`define DC_ADDR_W      32
`define DC_WORD_W      32

// four words per line
`define DC_LINE_WORDS  4
`define DC_LINE_W      128

// direct mapped, 256 lines
`define DC_INDEX_W     8
`define DC_LINES       256

// address split: tag 31..12, index 11..4, word 3..2
`define DC_TAG_W       20
`define DC_OFFSET_W    2
`define DC_STRB_W      4

`endif

//--- logic/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    //////////////////////////////
    // vector types
    //////////////////////////////

    // full byte address from the cpu
    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    // one cpu data word
    typedef logic [`DC_WORD_W-1:0]   word_t;
    // one whole cache line, word 0 in the low bits
    typedef logic [`DC_LINE_W-1:0]   line_t;
    // address fields
    typedef logic [`DC_TAG_W-1:0]    tag_t;
    typedef logic [`DC_INDEX_W-1:0]  index_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;
    // one enable per byte lane
    typedef logic [`DC_STRB_W-1:0]   strb_t;

    //////////////////////////////
    // controller states
    //////////////////////////////

    typedef enum logic [1:0] {
        compare_tag,
        writeback,
        allocate
    } cache_state_t;

endpackage

//--- logic/dcache_tag_store.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_tag_store (
    input  logic                clk,
    input  logic                reset,
    input  dcache_pkg::index_t  index,
    input  logic                fill_we,
    input  dcache_pkg::tag_t    fill_tag,
    input  logic                mark_dirty,
    output logic                entry_valid,
    output logic                entry_dirty,
    output dcache_pkg::tag_t    entry_tag
);

    // tag per line
    dcache_pkg::tag_t tags [`DC_LINES];

    // valid and dirty bit per line
    logic [`DC_LINES-1:0] valid_bits;
    logic [`DC_LINES-1:0] dirty_bits;

    //////////////////////////////
    // updates
    //////////////////////////////

    // new tag lands on a line fill
    always_ff @(posedge clk)
    begin
        if (fill_we)
            tags[index] <= fill_tag;
    end

    // fill makes the line valid and clean
    // a write hit only sets dirty
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end
        else if (fill_we)
        begin
            valid_bits[index] <= 1'b1;
            dirty_bits[index] <= 1'b0;
        end
        else if (mark_dirty)
            dirty_bits[index] <= 1'b1;
    end

    // asynchronous read of the indexed entry
    assign entry_valid = valid_bits[index];
    assign entry_dirty = dirty_bits[index];
    assign entry_tag   = tags[index];

    // the controller never fills and dirties a line in the same cycle
    a_fill_vs_dirty: assert property (@(posedge clk) disable iff (reset)
        !(fill_we && mark_dirty));

endmodule

//--- logic/dcache_line_store.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_line_store (
    input  logic                 clk,
    input  dcache_pkg::index_t   index,
    input  dcache_pkg::offset_t  offset,
    input  logic                 word_we,
    input  dcache_pkg::strb_t    wstrb,
    input  dcache_pkg::word_t    wdata,
    input  logic                 fill_we,
    input  dcache_pkg::line_t    fill_data,
    output dcache_pkg::line_t    line_rdata,
    output dcache_pkg::word_t    word_rdata
);

    // data array, contents only meaningful behind a valid tag
    dcache_pkg::line_t lines [`DC_LINES];

    // the line selected by the current index
    dcache_pkg::line_t cur_line;

    // cur_line with the strobed bytes of wdata dropped in
    dcache_pkg::line_t merged_line;

    //////////////////////////////
    // read side
    //////////////////////////////

    assign cur_line = lines[index];

    // whole line goes out for a victim writeback
    assign line_rdata = cur_line;

    // word pick by offset, word 0 sits in bits 31..0
    assign word_rdata = cur_line[offset*`DC_WORD_W +: `DC_WORD_W];

    //////////////////////////////
    // write side
    //////////////////////////////

    // byte merge into the offset word
    // each strobe bit moves its own lane of wdata
    always_comb
    begin
        merged_line = cur_line;
        for (int b = 0; b < `DC_STRB_W; b++)
        begin
            if (wstrb[b])
                merged_line[offset*`DC_WORD_W + b*8 +: 8] = wdata[b*8 +: 8];
        end
    end

    // fill replaces the line, a word write stores the merge
    always_ff @(posedge clk)
    begin
        if (fill_we)
            lines[index] <= fill_data;
        else if (word_we)
            lines[index] <= merged_line;
    end

    // fills happen in allocate, word writes in compare_tag
    a_fill_vs_word: assert property (@(posedge clk)
        !(fill_we && word_we));

endmodule

//--- logic/dcache_controller.sv
`timescale 1ns/1ns
`include "dcache_defs.svh"

module dcache_controller (
    input  logic                 clk,
    input  logic                 reset,

    // cpu request
    input  dcache_pkg::addr_t    cpu_addr,
    input  logic                 cpu_read,
    input  logic                 cpu_write,
    output logic                 cpu_done,

    // entry read back from the tag store
    input  logic                 entry_valid,
    input  logic                 entry_dirty,
    input  dcache_pkg::tag_t     entry_tag,

    // controls into both stores
    output dcache_pkg::index_t   index,
    output dcache_pkg::offset_t  offset,
    output logic                 word_we,
    output logic                 mark_dirty,
    output logic                 fill_we,
    output dcache_pkg::tag_t     fill_tag,

    // memory side
    input  logic                 mem_rvalid,
    input  logic                 mem_wack,
    output logic                 mem_read,
    output logic                 mem_write,
    output dcache_pkg::addr_t    mem_addr
);

    dcache_pkg::cache_state_t state;
    dcache_pkg::cache_state_t next_state;

    // tag field of the request
    dcache_pkg::tag_t req_tag;

    // either request level
    logic req;

    // stored line matches the request
    logic hit;

    //////////////////////////////
    // address split
    //////////////////////////////

    assign req_tag = cpu_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign index   = cpu_addr[`DC_ADDR_W-`DC_TAG_W-1 -: `DC_INDEX_W];
    assign offset  = cpu_addr[`DC_ADDR_W-`DC_TAG_W-`DC_INDEX_W-1 -: `DC_OFFSET_W];

    assign req = cpu_read | cpu_write;

    // hit is only trusted in compare_tag
    assign hit = entry_valid && (entry_tag == req_tag);

    // a fill always carries the tag of the pending request
    assign fill_tag = req_tag;

    //////////////////////////////
    // state register
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= dcache_pkg::compare_tag;
        else
            state <= next_state;
    end

    //////////////////////////////
    // next state and outputs
    //////////////////////////////

    always_comb
    begin
        // defaults: idle in every state
        next_state = state;
        cpu_done   = 1'b0;
        word_we    = 1'b0;
        mark_dirty = 1'b0;
        fill_we    = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        mem_addr   = '0;

        case (state)
            dcache_pkg::compare_tag:
            begin
                if (req && hit)
                begin
                    // served right here, zero wait
                    cpu_done = 1'b1;
                    if (cpu_write)
                    begin
                        word_we    = 1'b1;
                        mark_dirty = 1'b1;
                    end
                end
                else if (req)
                begin
                    // miss, flush a dirty victim first
                    if (entry_valid && entry_dirty)
                        next_state = dcache_pkg::writeback;
                    else
                        next_state = dcache_pkg::allocate;
                end
            end

            dcache_pkg::writeback:
            begin
                // victim line address comes from the stored tag
                mem_write = 1'b1;
                mem_addr  = {entry_tag, index,
                             {(`DC_ADDR_W-`DC_TAG_W-`DC_INDEX_W){1'b0}}};
                if (mem_wack)
                    next_state = dcache_pkg::allocate;
            end

            dcache_pkg::allocate:
            begin
                // fetch the line of the request
                mem_read = 1'b1;
                mem_addr = {req_tag, index,
                            {(`DC_ADDR_W-`DC_TAG_W-`DC_INDEX_W){1'b0}}};
                if (mem_rvalid)
                begin
                    // line and tag written at this edge
                    fill_we    = 1'b1;
                    next_state = dcache_pkg::compare_tag;
                end
            end

            default:
            begin
                next_state = dcache_pkg::compare_tag;
            end
        endcase
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_one_request: assert property (@(posedge clk) disable iff (reset)
        !(cpu_read && cpu_write));

    a_one_mem_op: assert property (@(posedge clk) disable iff (reset)
        !(mem_read && mem_write));

    // a pending request holds until done
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (req && !cpu_done) |=>
            ($stable(cpu_addr) && $stable(cpu_read) && $stable(cpu_write)));

endmodule

//--- logic/dcache.sv
`timescale 1ns/1ns

module dcache (
    input  logic               clk,
    input  logic               reset,

    // cpu side
    input  dcache_pkg::addr_t  cpu_addr,
    input  dcache_pkg::word_t  cpu_wdata,
    input  dcache_pkg::strb_t  cpu_wstrb,
    input  logic               cpu_read,
    input  logic               cpu_write,
    output logic               cpu_done,
    output dcache_pkg::word_t  cpu_rdata,

    // memory side, whole lines
    output logic               mem_read,
    output logic               mem_write,
    output dcache_pkg::addr_t  mem_addr,
    output dcache_pkg::line_t  mem_wdata,
    input  logic               mem_rvalid,
    input  dcache_pkg::line_t  mem_rdata,
    input  logic               mem_wack
);

    // controller to stores
    dcache_pkg::index_t   index;
    dcache_pkg::offset_t  offset;
    logic                 word_we;
    logic                 mark_dirty;
    logic                 fill_we;
    dcache_pkg::tag_t     fill_tag;

    // tag store back to controller
    logic                 entry_valid;
    logic                 entry_dirty;
    dcache_pkg::tag_t     entry_tag;

    dcache_controller ctrl0 (
        .clk(clk), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_read(cpu_read), .cpu_write(cpu_write),
        .cpu_done(cpu_done),
        .entry_valid(entry_valid), .entry_dirty(entry_dirty), .entry_tag(entry_tag),
        .index(index), .offset(offset), .word_we(word_we), .mark_dirty(mark_dirty),
        .fill_we(fill_we), .fill_tag(fill_tag),
        .mem_rvalid(mem_rvalid), .mem_wack(mem_wack),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr)
    );

    dcache_tag_store tags0 (
        .clk(clk), .reset(reset), .index(index),
        .fill_we(fill_we), .fill_tag(fill_tag), .mark_dirty(mark_dirty),
        .entry_valid(entry_valid), .entry_dirty(entry_dirty), .entry_tag(entry_tag)
    );

    // fill data from memory, victim line and read word straight out
    dcache_line_store lines0 (
        .clk(clk), .index(index), .offset(offset),
        .word_we(word_we), .wstrb(cpu_wstrb), .wdata(cpu_wdata),
        .fill_we(fill_we), .fill_data(mem_rdata),
        .line_rdata(mem_wdata), .word_rdata(cpu_rdata)
    );

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    logic               clk;
    logic               reset;
    dcache_pkg::addr_t  cpu_addr;
    dcache_pkg::word_t  cpu_wdata;
    logic [3:0]         cpu_wstrb;
    logic               cpu_read;
    logic               cpu_write;
    logic               cpu_done;
    dcache_pkg::word_t  cpu_rdata;
    logic               mem_read;
    logic               mem_write;
    dcache_pkg::addr_t  mem_addr;
    dcache_pkg::line_t  mem_wdata;
    logic               mem_rvalid;
    dcache_pkg::line_t  mem_rdata;
    logic               mem_wack;

    // lfsr, memory model contents and the cpu-side shadow of every word
    logic [31:0]        lfsr_state;
    dcache_pkg::line_t  mem_lines [dcache_pkg::addr_t];
    dcache_pkg::word_t  shadow [dcache_pkg::addr_t];
    // memory operations in the order the cache issued them
    logic               log_is_write [$];
    dcache_pkg::addr_t  log_addr [$];
    int                 mem_ops;
    // per test and overall results
    string              test_name;
    int                 test_errors;
    int                 pass_count;
    int                 fail_count;
    logic               timed_out;
    // tags and indices that the random traffic mixes
    logic [19:0]        tag_list [3];
    logic [7:0]         idx_list [4];

    dcache dut0 (
        .clk(clk), .reset(reset),
        .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata), .cpu_wstrb(cpu_wstrb),
        .cpu_read(cpu_read), .cpu_write(cpu_write),
        .cpu_done(cpu_done), .cpu_rdata(cpu_rdata),
        .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .mem_wack(mem_wack)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // galois lfsr, one step per bit taken, newest bit lands in bit 0
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state >> 1;
            if (v[0])
                lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return v;
    endfunction

    // a byte lane takes the new data only where its strobe is set
    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input logic [3:0] st);
        dcache_pkg::word_t r;
        r = old_w;
        for (int b = 0; b < 4; b++)
        begin
            if (st[b])
                r[b*8 +: 8] = new_w[b*8 +: 8];
        end
        return r;
    endfunction

    // expected read data: the cache must look like plain memory
    function automatic dcache_pkg::word_t exp_read(input dcache_pkg::addr_t a);
        return shadow[{a[31:2], 2'b00}];
    endfunction

    // shadow words of one line, word 0 in the low bits
    function automatic dcache_pkg::line_t shadow_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        for (int w = 0; w < 4; w++)
            l[w*32 +: 32] = shadow[{a[31:4], 4'h0} + 32'(w*4)];
        return l;
    endfunction

    // random contents on first touch, mirrored into the shadow
    function automatic dcache_pkg::line_t touch_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        if (!mem_lines.exists(a))
        begin
            for (int w = 0; w < 4; w++)
            begin
                l[w*32 +: 32] = take_bits(32);
                shadow[a + 32'(w*4)] = l[w*32 +: 32];
            end
            mem_lines[a] = l;
        end
        return mem_lines[a];
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (!timed_out && exp_v !== act_v)
        begin
            $display("** Error %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
            test_errors++;
        end
    endtask

    // one cpu request, entered and left at 1 ns after a rising edge
    task automatic access(input logic wr, input dcache_pkg::addr_t a,
                          input dcache_pkg::word_t wd, input logic [3:0] st,
                          output dcache_pkg::word_t rd);
        int   cycles;
        logic done_seen;
        cycles = 0;
        done_seen = 1'b0;
        rd = '0;
        if (!timed_out)
        begin
            cpu_addr  = a;
            cpu_wdata = wd;
            cpu_wstrb = st;
            cpu_read  = !wr;
            cpu_write = wr;
            while (!done_seen && cycles < 200)
            begin
                // mid-cycle, all combinational outputs have settled
                @(negedge clk);
                if (cpu_done)
                begin
                    done_seen = 1'b1;
                    rd = cpu_rdata;
                end
                @(posedge clk);
                #1;
                cycles++;
            end
            cpu_read  = 1'b0;
            cpu_write = 1'b0;
            if (!done_seen)
            begin
                $display("%s: timeout, no cpu_done within 200 cycles at address %h",
                         test_name, a);
                timed_out = 1'b1;
            end
            else if (wr)
                shadow[{a[31:2], 2'b00}] = merge_bytes(exp_read(a), wd, st);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errors = 0;
        log_is_write.delete();
        log_addr.delete();
    endtask

    task automatic end_test();
        if (test_errors == 0 && !timed_out)
        begin
            pass_count++;
            $display("%s: ok", test_name);
        end
        else
        begin
            fail_count++;
            $display("%s: %0d errors", test_name, test_errors);
        end
    endtask

    //////////////////////////////
    // memory model
    //////////////////////////////

    // sees each level mid-cycle, answers 0 to 3 cycles later with a pulse
    always
    begin
        dcache_pkg::addr_t op_addr;
        dcache_pkg::line_t rd_line;
        logic              op_wr;
        int                delay;
        @(negedge clk);
        if (!reset && (mem_read || mem_write))
        begin
            op_addr = mem_addr;
            op_wr   = mem_write;
            mem_ops++;
            log_is_write.push_back(op_wr);
            log_addr.push_back(op_addr);
            if (op_wr)
            begin
                // a victim always holds the latest cpu view of its line
                if (mem_wdata !== shadow_line(op_addr))
                begin
                    $display("** Error %s: writeback line %h expected %h actual %h",
                             test_name, op_addr, shadow_line(op_addr), mem_wdata);
                    test_errors++;
                end
                mem_lines[op_addr] = mem_wdata;
            end
            else
                rd_line = touch_line(op_addr);
            delay = int'(take_bits(2));
            repeat (delay) @(posedge clk);
            @(posedge clk);
            #1;
            mem_rdata  = op_wr ? '0 : rd_line;
            mem_rvalid = !op_wr;
            mem_wack   = op_wr;
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
            mem_wack   = 1'b0;
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////

    initial
    begin
        dcache_pkg::addr_t a;
        dcache_pkg::word_t rd;
        logic [31:0]       r;
        int                ops0;
        int                tsel;
        int                isel;
        lfsr_state = 32'h21e5989f;
        tag_list[0] = 20'h00012;
        tag_list[1] = 20'h00077;
        tag_list[2] = 20'h00abc;
        idx_list[0] = 8'h34;
        idx_list[1] = 8'h35;
        idx_list[2] = 8'h80;
        idx_list[3] = 8'hff;
        mem_ops = 0;
        pass_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        cpu_read = 1'b0;
        cpu_write = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata = '0;
        mem_wack = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        // miss on an empty cache, one line fetch
        start_test("cold_read");
        access(1'b0, 32'h0001_2344, '0, '0, rd);
        check_value("read data", exp_read(32'h0001_2344), rd);
        if (!timed_out && (log_addr.size() != 1 || log_is_write[0]))
        begin
            $display("%s: expected one line read, saw %0d memory operations",
                     test_name, log_addr.size());
            test_errors++;
        end
        else if (!timed_out)
            check_value("fetch address", 32'h0001_2340, log_addr[0]);
        end_test();

        // every word of the filled line, no traffic
        start_test("read_hit");
        ops0 = mem_ops;
        for (int w = 0; w < 4; w++)
        begin
            a = 32'h0001_2340 + 32'(w*4);
            access(1'b0, a, '0, '0, rd);
            check_value("read data", exp_read(a), rd);
        end
        check_value("memory operations", 32'(ops0), 32'(mem_ops));
        end_test();

        // partial strobes, then read each word back
        start_test("write_hit");
        ops0 = mem_ops;
        access(1'b1, 32'h0001_2340, 32'hdead_beef, 4'b0101, rd);
        access(1'b1, 32'h0001_2344, 32'h1234_5678, 4'b0010, rd);
        access(1'b1, 32'h0001_2348, 32'hcafe_f00d, 4'b1000, rd);
        access(1'b1, 32'h0001_234c, 32'h0bad_c0de, 4'b1111, rd);
        for (int w = 0; w < 4; w++)
        begin
            a = 32'h0001_2340 + 32'(w*4);
            access(1'b0, a, '0, '0, rd);
            check_value("read back", exp_read(a), rd);
        end
        check_value("memory operations", 32'(ops0), 32'(mem_ops));
        end_test();

        // same index, new tag: dirty line goes out before the fetch
        start_test("dirty_evict");
        access(1'b0, 32'h0007_7348, '0, '0, rd);
        check_value("read data", exp_read(32'h0007_7348), rd);
        if (!timed_out && (log_addr.size() != 2 || !log_is_write[0] || log_is_write[1]))
        begin
            $display("%s: expected a writeback then a line read, saw %0d memory operations",
                     test_name, log_addr.size());
            test_errors++;
        end
        else if (!timed_out)
        begin
            check_value("victim address", 32'h0001_2340, log_addr[0]);
            check_value("fetch address", 32'h0007_7340, log_addr[1]);
        end
        end_test();

        // mixed reads and writes over a few conflicting lines
        start_test("random_traffic");
        for (int n = 0; n < 300; n++)
        begin
            r = take_bits(2);
            tsel = int'(r % 3);
            r = take_bits(2);
            isel = int'(r);
            r = take_bits(2);
            a = {tag_list[tsel], idx_list[isel], r[1:0], 2'b00};
            r = take_bits(1);
            if (r[0])
                access(1'b1, a, take_bits(32), 4'(take_bits(4)), rd);
            else
            begin
                access(1'b0, a, '0, '0, rd);
                check_value("read data", exp_read(a), rd);
            end
        end
        end_test();

        $display("%0d tests ok, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0 && !timed_out)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

//--- dcache.f
+incdir+logic
logic/dcache_pkg.sv
logic/dcache_tag_store.sv
logic/dcache_line_store.sv
logic/dcache_controller.sv
logic/dcache.sv
bench/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the dcache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert \
    -f dcache.f \
    --top-module dcache_tb \
    -o dcache_sim

./obj_dir/dcache_sim > sim.log
cat sim.log

if grep -qx "test passed" sim.log
then
    exit 0
fi
exit 1
